// File: design/cb_config.svh
`ifndef CB_CONFIG_SVH
`define CB_CONFIG_SVH

// node address width and symbol width
`define HT_ADDR_W 8

// words in the node memory
`define HT_DEPTH 256

// path register holds a leading marker 1 followed by the moves
`define CODE_W 128

// code length width covering CODE_W-1 moves
`define LEN_W 7

// child field for no element has the flag set and index 0x80
`define NULL_CHILD 9'h180

`endif

// File: design/htree_pkg.sv
`default_nettype none

`include "cb_config.svh"

package htree_pkg;

    // one child slot of a tree node whose flag picks the view
    typedef union packed {
        struct packed {
            logic                  is_sum;   // set when the child is an inner node
            logic [`HT_ADDR_W-1:0] node_idx; // address of that node
        } node;
        struct packed {
            logic                  is_sum;   // clear when the child is a leaf
            logic [`HT_ADDR_W-1:0] symbol;   // leaf symbol
        } leaf;
    } htree_child_u;

    // a stored node word with the left child in the upper half
    typedef struct packed {
        htree_child_u left;
        htree_child_u right;
    } htree_node_t;

endpackage

`default_nettype wire

// File: design/codebook_pkg.sv
`default_nettype none

package codebook_pkg;

    // walker FSM states
    typedef enum logic [2:0] {
        INIT,       // idle after reset
        LEFT,       // descend by the left child and append 0
        RIGHT,      // take the right child once and append 1
        TRACK,      // re-walk the stored path from the root
        BACKTRACK,  // undo moves until a left move is found
        SEND,       // wait for the table to store the leaf
        FINISH      // hold after the walk until the next start
    } cb_state_t;

endpackage

`default_nettype wire

// File: design/htree_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module htree_loader
    import htree_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  node_wr,    // one node word per strobe
    input  htree_node_t           node_data,
    input  logic                  load_done,  // closes the current load
    output logic                  mem_we,
    output logic [`HT_ADDR_W-1:0] mem_waddr,
    output htree_node_t           mem_wdata,
    output logic [`HT_ADDR_W-1:0] root_index, // last node of the load
    output logic                  walk_start
);

    logic [`HT_ADDR_W-1:0] wr_ptr;    // next free node address
    logic [`HT_ADDR_W-1:0] last_addr; // most recently written node

    assign mem_we    = node_wr;   // write goes out in the strobe cycle
    assign mem_waddr = wr_ptr;
    assign mem_wdata = node_data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            last_addr  <= '0;
            root_index <= '0;
            walk_start <= 1'b0;
        end else begin
            walk_start <= load_done; // one cycle behind load_done
            if (node_wr) begin
                wr_ptr    <= wr_ptr + 1'b1;
                last_addr <= wr_ptr;
            end
            if (load_done) begin
                wr_ptr     <= '0; // next load starts again at 0
                root_index <= node_wr ? wr_ptr : last_addr; // root is the last node
            end
        end
    end

endmodule

`default_nettype wire

// File: design/htree_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module htree_mem
    import htree_pkg::*;
(
    input  logic                  clk,
    input  logic                  we,
    input  logic [`HT_ADDR_W-1:0] waddr,
    input  htree_node_t           wdata,
    input  logic [`HT_ADDR_W-1:0] rd_index,
    output htree_node_t           rd_node   // valid one cycle after rd_index
);

    htree_node_t nodes [0:`HT_DEPTH-1]; // tree node storage

    always_ff @(posedge clk) begin
        if (we) begin
            nodes[waddr] <= wdata;
        end
        rd_node <= nodes[rd_index]; // registered read port
    end

endmodule

`default_nettype wire

// File: design/cb_synthesis.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module cb_synthesis
    import htree_pkg::*, codebook_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  walk_start,
    input  logic [`HT_ADDR_W-1:0] root_index,
    input  htree_node_t           rd_node,
    input  logic                  write_done,
    output logic [`HT_ADDR_W-1:0] rd_index,
    output logic                  char_found,
    output logic [`HT_ADDR_W-1:0] char_symbol,
    output logic [`CODE_W-1:0]    char_code,
    output logic [`LEN_W-1:0]     char_len,
    output logic                  finished
);

    localparam logic [`CODE_W-1:0] CODE_ONE = 1; // empty path holding only the marker

    cb_state_t             state, next_state;
    logic [`CODE_W-1:0]    path, next_path;   // marker then moves with the newest in bit 0
    logic [`LEN_W-1:0]     depth, next_depth; // moves held in path
    logic [`LEN_W-1:0]     pos, next_pos;     // moves replayed in TRACK
    logic                  wait_cycle, next_wait;
    logic [`HT_ADDR_W-1:0] next_index;
    logic                  step_right;        // current move goes right
    htree_child_u          step_c;            // child taken by this move
    logic                  track_bit;         // stored move replayed next

    assign step_right = (state == RIGHT);
    assign step_c     = step_right ? rd_node.right : rd_node.left;
    assign track_bit  = path[depth - pos - 1'b1]; // first move sits highest

    always_comb begin
        next_state  = state;
        next_path   = path;
        next_depth  = depth;
        next_pos    = pos;
        next_wait   = wait_cycle;
        next_index  = rd_index;
        char_found  = 1'b0;
        char_symbol = '0;
        char_code   = '0;
        char_len    = '0;
        case (state)
            INIT: begin
                next_state = INIT; // idle until walk_start
            end
            LEFT, RIGHT: begin
                if (wait_cycle) begin
                    next_wait = 1'b0; // node read still in flight
                end else if (step_c == `NULL_CHILD) begin
                    next_state = FINISH; // single leaf tree or root exhausted
                end else begin
                    next_path  = {path[`CODE_W-2:0], step_right};
                    next_depth = depth + 1'b1;
                    if (step_c.node.is_sum) begin
                        next_index = step_c.node.node_idx;
                        next_wait  = 1'b1;
                        next_state = LEFT; // always go left first in a new subtree
                    end else begin
                        char_found  = 1'b1;
                        char_symbol = step_c.leaf.symbol;
                        char_code   = next_path ^ (CODE_ONE << next_depth); // drop marker
                        char_len    = next_depth;
                        next_state  = SEND;
                    end
                end
            end
            SEND: begin
                if (write_done) begin
                    next_state = BACKTRACK;
                end
            end
            BACKTRACK: begin
                if (depth == '0) begin
                    next_state = FINISH; // every move undone so the tree is fully walked
                end else begin
                    next_path  = {1'b0, path[`CODE_W-1:1]}; // pop newest move
                    next_depth = depth - 1'b1;
                    if (!path[0]) begin
                        // popped a left move whose right sibling is still open
                        next_state = TRACK;
                        next_index = root_index;
                        next_pos   = '0;
                        next_wait  = 1'b1;
                    end
                end
            end
            TRACK: begin
                if (wait_cycle) begin
                    next_wait = 1'b0;
                end else if (pos < depth) begin
                    next_index = track_bit ? rd_node.right.node.node_idx
                                           : rd_node.left.node.node_idx;
                    next_pos   = pos + 1'b1;
                    next_wait  = 1'b1;
                end else begin
                    next_state = RIGHT; // rd_node already holds the parent
                end
            end
            FINISH: begin
                next_state = FINISH;
            end
            default: begin
                next_state = INIT;
            end
        endcase
        if (walk_start) begin
            // restart from the root with an empty path
            next_state = LEFT;
            next_path  = CODE_ONE;
            next_depth = '0;
            next_pos   = '0;
            next_index = root_index;
            next_wait  = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= INIT;
            path       <= CODE_ONE;
            depth      <= '0;
            pos        <= '0;
            wait_cycle <= 1'b1;
            rd_index   <= '0;
            finished   <= 1'b0;
        end else begin
            state      <= next_state;
            path       <= next_path;
            depth      <= next_depth;
            pos        <= next_pos;
            wait_cycle <= next_wait;
            rd_index   <= next_index;
            finished   <= (next_state == FINISH) && (state != FINISH); // one pulse
        end
    end

endmodule

`default_nettype wire

// File: design/codebook_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module codebook_store (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,        // drop every entry
    input  logic                  wr,
    input  logic [`HT_ADDR_W-1:0] wr_sym,
    input  logic [`CODE_W-1:0]    wr_code,
    input  logic [`LEN_W-1:0]     wr_len,
    output logic                  write_done,   // one cycle after wr
    input  logic [`HT_ADDR_W-1:0] lookup_sym,
    output logic [`CODE_W-1:0]    lookup_code,
    output logic [`LEN_W-1:0]     lookup_len,
    output logic                  lookup_valid
);

    localparam int NUM_SYM = 1 << `HT_ADDR_W; // one entry per symbol value

    logic [`CODE_W-1:0] code_mem [0:NUM_SYM-1];
    logic [`LEN_W-1:0]  len_mem  [0:NUM_SYM-1];
    logic [NUM_SYM-1:0] valid;                  // entry written since last clear

    always_ff @(posedge clk) begin
        if (wr) begin
            code_mem[wr_sym] <= wr_code;
            len_mem[wr_sym]  <= wr_len;
        end
        lookup_code <= code_mem[lookup_sym]; // registered lookup
        lookup_len  <= len_mem[lookup_sym];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid        <= '0;
            write_done   <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            write_done   <= wr;
            lookup_valid <= valid[lookup_sym];
            if (clear) begin
                valid <= '0; // a new walk makes the old codes stale
            end else if (wr) begin
                valid[wr_sym] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/huff_codebook_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module huff_codebook_top
    import htree_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  node_wr,
    input  htree_node_t           node_data,
    input  logic                  load_done,
    input  logic [`HT_ADDR_W-1:0] lookup_sym,
    output logic [`CODE_W-1:0]    lookup_code,
    output logic [`LEN_W-1:0]     lookup_len,
    output logic                  lookup_valid,
    output logic                  finished
);

    logic                  mem_we;
    logic [`HT_ADDR_W-1:0] mem_waddr;
    htree_node_t           mem_wdata;
    logic [`HT_ADDR_W-1:0] root_index;
    logic                  walk_start;  // also clears the table
    logic [`HT_ADDR_W-1:0] rd_index;
    htree_node_t           rd_node;
    logic                  char_found;
    logic [`HT_ADDR_W-1:0] char_symbol;
    logic [`CODE_W-1:0]    char_code;
    logic [`LEN_W-1:0]     char_len;
    logic                  write_done;

    htree_loader htree_loader_i (
        .clk(clk), .rst(rst), .node_wr(node_wr), .node_data(node_data),
        .load_done(load_done), .mem_we(mem_we), .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata), .root_index(root_index), .walk_start(walk_start)
    );

    htree_mem htree_mem_i (
        .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
        .rd_index(rd_index), .rd_node(rd_node)
    );

    cb_synthesis cb_synthesis_i (
        .clk(clk), .rst(rst), .walk_start(walk_start), .root_index(root_index),
        .rd_node(rd_node), .write_done(write_done), .rd_index(rd_index),
        .char_found(char_found), .char_symbol(char_symbol), .char_code(char_code),
        .char_len(char_len), .finished(finished)
    );

    codebook_store codebook_store_i (
        .clk(clk), .rst(rst), .clear(walk_start), .wr(char_found),
        .wr_sym(char_symbol), .wr_code(char_code), .wr_len(char_len),
        .write_done(write_done), .lookup_sym(lookup_sym), .lookup_code(lookup_code),
        .lookup_len(lookup_len), .lookup_valid(lookup_valid)
    );

endmodule

`default_nettype wire

// File: tb/tb_huff_codebook.sv
`timescale 1ns/1ps
`default_nettype none

`include "cb_config.svh"

module tb_huff_codebook
    import htree_pkg::*, codebook_pkg::*;
();

    localparam int WAIT_LIMIT = 20000; // cycles allowed for one walk

    logic                  clk;
    logic                  rst;
    logic                  node_wr;
    htree_node_t           node_data;
    logic                  load_done;
    logic [`HT_ADDR_W-1:0] lookup_sym;
    logic [`CODE_W-1:0]    lookup_code;
    logic [`LEN_W-1:0]     lookup_len;
    logic                  lookup_valid;
    logic                  finished;

    htree_node_t           tree      [0:`HT_DEPTH-1]; // node words with the root last
    int                    n_nodes;
    logic [`CODE_W-1:0]    exp_code  [0:`HT_DEPTH-1]; // model result per symbol
    logic [`LEN_W-1:0]     exp_len   [0:`HT_DEPTH-1];
    logic                  exp_valid [0:`HT_DEPTH-1];
    logic [`HT_ADDR_W-1:0] stk_idx   [0:`HT_DEPTH-1]; // model DFS stack
    logic [`CODE_W-1:0]    stk_code  [0:`HT_DEPTH-1];
    logic [`LEN_W-1:0]     stk_len   [0:`HT_DEPTH-1];
    htree_child_u          pool      [0:15];          // subtrees not yet merged
    int                    pool_n;
    logic [31:0]           rng;
    int                    errors;
    int                    checks;

    huff_codebook_top huff_codebook_top_i (
        .clk(clk), .rst(rst), .node_wr(node_wr), .node_data(node_data),
        .load_done(load_done), .lookup_sym(lookup_sym), .lookup_code(lookup_code),
        .lookup_len(lookup_len), .lookup_valid(lookup_valid), .finished(finished)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic htree_child_u leaf_child(input logic [`HT_ADDR_W-1:0] sym);
        htree_child_u c;
        c.leaf.is_sum = 1'b0;
        c.leaf.symbol = sym;
        return c;
    endfunction

    function automatic htree_child_u sum_child(input logic [`HT_ADDR_W-1:0] idx);
        htree_child_u c;
        c.node.is_sum   = 1'b1;
        c.node.node_idx = idx;
        return c;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1; // inputs change just after the edge
    endtask

    // appends a node word and hands back a child field that points at it
    task automatic add_node(input htree_child_u l, input htree_child_u r,
                            output htree_child_u sum);
        tree[n_nodes].left  = l;
        tree[n_nodes].right = r;
        sum = sum_child(8'(n_nodes));
        n_nodes++;
    endtask

    // expected codes from a walk down from the root where left adds 0 and right adds 1
    task automatic model_codes();
        htree_node_t        node;
        htree_child_u       c;
        logic [`CODE_W-1:0] code;
        logic [`LEN_W-1:0]  len;
        int                 sp;
        for (int s = 0; s < `HT_DEPTH; s++) begin
            exp_valid[s] = 1'b0; // a new load forgets the old codes
        end
        sp          = 1;
        stk_idx[0]  = 8'(n_nodes - 1);
        stk_code[0] = '0;
        stk_len[0]  = '0;
        while (sp > 0) begin
            sp--;
            node = tree[stk_idx[sp]];
            code = stk_code[sp];
            len  = stk_len[sp];
            for (int side = 0; side < 2; side++) begin
                c = (side == 1) ? node.right : node.left;
                if (c != `NULL_CHILD) begin
                    if (c.node.is_sum) begin
                        stk_idx[sp]  = c.node.node_idx;
                        stk_code[sp] = (code << 1) | `CODE_W'(side);
                        stk_len[sp]  = len + 1'b1;
                        sp++;
                    end else begin
                        exp_code[c.leaf.symbol]  = (code << 1) | `CODE_W'(side);
                        exp_len[c.leaf.symbol]   = len + 1'b1;
                        exp_valid[c.leaf.symbol] = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic load_tree();
        for (int i = 0; i < n_nodes; i++) begin
            next_cycle();
            node_wr   = 1'b1;
            node_data = tree[i];
        end
        next_cycle();
        node_wr   = 1'b0;
        load_done = 1'b1; // root is the last node written
        next_cycle();
        load_done = 1'b0;
        model_codes();
    endtask

    task automatic wait_finished();
        int        n;
        logic      seen;
        cb_state_t st;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            seen = finished;
            n++;
        end
        if (!seen) begin
            st = huff_codebook_top_i.cb_synthesis_i.state;
            errors++;
            $display("timeout after %0d cycles without a finished pulse, walker in %s",
                     n, st.name());
        end
    endtask

    task automatic verify_code(input string name, input logic [`CODE_W-1:0] exp,
                               input logic [`CODE_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic match_len(input string name, input logic [`LEN_W-1:0] exp,
                             input logic [`LEN_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic compare_valid(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_code(input logic [`HT_ADDR_W-1:0] sym,
                              input logic [`CODE_W-1:0] code,
                              input logic [`LEN_W-1:0] len, input logic valid);
        next_cycle();
        lookup_sym = sym;
        @(posedge clk); // lookup is registered
        @(negedge clk);
        compare_valid($sformatf("lookup_valid[%02h]", sym), valid, lookup_valid);
        if (valid) begin
            verify_code($sformatf("lookup_code[%02h]", sym), code, lookup_code);
            match_len($sformatf("lookup_len[%02h]", sym), len, lookup_len);
        end
    endtask

    task automatic sweep_symbols();
        for (int s = 0; s < `HT_DEPTH; s++) begin
            check_code(8'(s), exp_code[s], exp_len[s], exp_valid[s]);
        end
    endtask

    task automatic pick_from_pool(output htree_child_u c);
        int i;
        rng = xorshift32(rng);
        i   = int'(rng % 32'(pool_n));
        c   = pool[i];
        pool[i] = pool[pool_n - 1]; // fill the hole with the last entry
        pool_n--;
    endtask

    task automatic balanced_tree(input logic [`HT_ADDR_W-1:0] base);
        htree_child_u a, b, r;
        n_nodes = 0;
        add_node(leaf_child(base), leaf_child(base + 8'd1), a);
        add_node(leaf_child(base + 8'd2), leaf_child(base + 8'd3), b);
        add_node(a, b, r);
        load_tree();
        wait_finished();
        sweep_symbols();
    endtask

    task automatic skewed_tree(input logic [`HT_ADDR_W-1:0] base);
        htree_child_u sub;
        n_nodes = 0;
        add_node(leaf_child(base), leaf_child(base + 8'd1), sub); // deepest pair
        for (int k = 2; k < 7; k++) begin
            if (k % 2 == 1) begin
                add_node(leaf_child(base + 8'(k)), sub, sub); // chain turns right
            end else begin
                add_node(sub, leaf_child(base + 8'(k)), sub);
            end
        end
        load_tree();
        wait_finished();
        sweep_symbols();
    endtask

    task automatic single_leaf_tree();
        htree_child_u r;
        n_nodes = 0;
        add_node(leaf_child(8'h30), `NULL_CHILD, r);
        load_tree();
        wait_finished();
        check_code(8'h30, '0, 7'd1, 1'b1); // the only code is 0
        sweep_symbols();
    endtask

    task automatic unknown_symbol();
        check_code(8'hff, '0, '0, 1'b0);
    endtask

    task automatic reload_tree();
        balanced_tree(8'h60);
        check_code(8'h30, '0, '0, 1'b0); // previous tree's leaf is gone
    endtask

    task automatic random_tree();
        htree_child_u a, b, s;
        n_nodes = 0;
        for (int k = 0; k < 12; k++) begin
            pool[k] = leaf_child(8'h80 + 8'(k * 5));
        end
        pool_n = 12;
        while (pool_n > 1) begin
            pick_from_pool(a);
            pick_from_pool(b);
            add_node(a, b, s);
            pool[pool_n] = s; // merged subtree goes back in
            pool_n++;
        end
        load_tree();
        wait_finished();
        sweep_symbols();
    endtask

    initial begin
        rst        = 1'b1;
        node_wr    = 1'b0;
        node_data  = '0;
        load_done  = 1'b0;
        lookup_sym = '0;
        errors     = 0;
        checks     = 0;
        n_nodes    = 0;
        pool_n     = 0;
        rng        = 32'h87ee_a810;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare_valid("finished", 1'b0, finished);
        compare_valid("lookup_valid", 1'b0, lookup_valid);
        balanced_tree(8'h10);
        skewed_tree(8'h20);
        single_leaf_tree();
        unknown_symbol();
        reload_tree();
        random_tree();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/htree_pkg.sv
design/codebook_pkg.sv
design/htree_loader.sv
design/htree_mem.sv
design/cb_synthesis.sv
design/codebook_store.sv
design/huff_codebook_top.sv
tb/tb_huff_codebook.sv

// File: run.sh
#!/usr/bin/env bash
# build the codebook testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_huff_codebook

output=$(./obj_dir/Vtb_huff_codebook)
echo "$output"

# the run counts as passed only if the testbench printed the pass line
if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
